// ==== hdl/flight_control_top.sv ====
`timescale 1ns/1ns

module flight_control_top (
	output flight_pkg::motors_t motors,
	output logic motors_valid,
	output flight_pkg::rates_t rates,
	output logic busy,
	input logic sample_strobe,
	input flight_pkg::axis_in_t roll_in,
	input flight_pkg::axis_in_t pitch_in,
	input flight_pkg::axis_in_t yaw_in,
	input flight_pkg::motor_cmd_t throttle,
	input logic resetn,
	input logic us_clk
);

	logic rates_valid; // one cycle ahead of motors_valid.

	rate_controller rate_controller_inst (
		.rates(rates),
		.rates_valid(rates_valid),
		.busy(busy),
		.sample_strobe(sample_strobe),
		.roll_in(roll_in),
		.pitch_in(pitch_in),
		.yaw_in(yaw_in),
		.resetn(resetn),
		.us_clk(us_clk)
	);

	// throttle is sampled by the mixer together with the rates.
	motor_mixer motor_mixer_inst (
		.motors(motors),
		.motors_valid(motors_valid),
		.rates(rates),
		.rates_valid(rates_valid),
		.throttle(throttle),
		.resetn(resetn),
		.us_clk(us_clk)
	);

endmodule

// ==== hdl/flight_pkg.sv ====
package flight_pkg;

	// widths of the quantities that move through the rate loop.
	localparam int rate_w = 16;
	localparam int imu_w = 16;
	localparam int acc_w = 24; // room for gain products and three-term sums.
	localparam int motor_w = 12;

	typedef logic signed [rate_w-1:0] rate_t;
	typedef logic signed [imu_w-1:0] imu_val_t;
	typedef logic signed [acc_w-1:0] rate_acc_t;
	typedef logic [motor_w-1:0] motor_cmd_t;

	// limits of a pid output and of a motor command.
	localparam rate_t rate_min = 16'sh8000;
	localparam rate_t rate_max = 16'sh7fff;
	localparam motor_cmd_t motor_max = 12'd4095;

	// roll and pitch share one tuning.
	localparam rate_acc_t roll_kp = 24'sd2;
	localparam rate_acc_t roll_ki = 24'sd1;
	localparam rate_acc_t roll_kd = 24'sd1;
	localparam rate_acc_t pitch_kp = 24'sd2;
	localparam rate_acc_t pitch_ki = 24'sd1;
	localparam rate_acc_t pitch_kd = 24'sd1;

	// Yaw runs without the integral term.
	localparam rate_acc_t yaw_kp = 24'sd3;
	localparam rate_acc_t yaw_ki = 24'sd0;
	localparam rate_acc_t yaw_kd = 24'sd1;

	typedef struct packed {
		rate_t target; // commanded rotation rate.
		imu_val_t actual; // rate reported by the gyro.
		rate_t angle_error; // error term from the outer angle loop.
	} axis_in_t;

	typedef struct packed {
		rate_t roll;
		rate_t pitch;
		rate_t yaw;
	} rates_t;

	typedef struct packed {
		motor_cmd_t front_left;
		motor_cmd_t front_right;
		motor_cmd_t rear_left;
		motor_cmd_t rear_right;
	} motors_t;

	typedef enum logic [2:0] {
		pid_idle,
		pid_calc1,
		pid_calc2,
		pid_calc3,
		pid_calc4,
		pid_done
	} pid_state_t;

	typedef enum logic [1:0] {
		seq_idle,
		seq_run,
		seq_collect
	} seq_state_t;

endpackage

// ==== hdl/motor_mixer.sv ====
`timescale 1ns/1ns

module motor_mixer (
	output flight_pkg::motors_t motors,
	output logic motors_valid,
	input flight_pkg::rates_t rates,
	input logic rates_valid,
	input flight_pkg::motor_cmd_t throttle,
	input logic resetn,
	input logic us_clk
);
	import flight_pkg::*;

	rate_acc_t base; // throttle in the signed working width.
	rate_acc_t roll_c, pitch_c, yaw_c;
	rate_acc_t mix_fl, mix_fr, mix_rl, mix_rr;

	function automatic motor_cmd_t clamp_motor(input rate_acc_t mix);
		rate_acc_t limit;
		limit = rate_acc_t'({{(acc_w - motor_w){1'b0}}, motor_max});
		if (mix < 0)
			return '0;
		else if (mix > limit)
			return motor_max;
		else
			return motor_cmd_t'(mix);
	endfunction

	assign base = rate_acc_t'({{(acc_w - motor_w){1'b0}}, throttle});
	assign roll_c = rate_acc_t'(rates.roll);
	assign pitch_c = rate_acc_t'(rates.pitch);
	assign yaw_c = rate_acc_t'(rates.yaw);

	// quad-X layout. Diagonal motor pairs spin the same way, so yaw flips
	// sign between the two diagonals.
	assign mix_fl = base + roll_c + pitch_c - yaw_c;
	assign mix_fr = base - roll_c + pitch_c + yaw_c;
	assign mix_rl = base + roll_c - pitch_c + yaw_c;
	assign mix_rr = base - roll_c - pitch_c - yaw_c;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			motors <= '0; // motors stay off until the first result.
		end else if (rates_valid) begin
			motors.front_left <= clamp_motor(mix_fl);
			motors.front_right <= clamp_motor(mix_fr);
			motors.rear_left <= clamp_motor(mix_rl);
			motors.rear_right <= clamp_motor(mix_rr);
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			motors_valid <= 1'b0;
		else
			motors_valid <= rates_valid; // one-cycle pulse behind rates_valid.
	end

endmodule

// ==== hdl/pid.sv ====
`timescale 1ns/1ns

module pid #(
	parameter flight_pkg::rate_acc_t k_p = 24'sd1,
	parameter flight_pkg::rate_acc_t k_i = 24'sd1,
	parameter flight_pkg::rate_acc_t k_d = 24'sd1
) (
	output flight_pkg::rate_t rate_out,
	output logic pid_complete,
	output logic pid_active,
	input flight_pkg::rate_t target_rotation,
	input flight_pkg::imu_val_t actual_rotation,
	input flight_pkg::rate_t angle_error,
	input logic start_flag,
	input logic wait_flag,
	input logic resetn,
	input logic us_clk
);
	import flight_pkg::*;

	pid_state_t state, next_state;

	rate_acc_t rotation_error; // error of the current sample.
	rate_acc_t prev_rotation_error; // error of the sample before.
	rate_acc_t term_p, term_i, term_d;
	rate_acc_t error_change;
	rate_acc_t rotation_total;
	rate_t total_sat;

	assign pid_active = (state != pid_idle);

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			state <= pid_idle;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			pid_idle: if (start_flag) next_state = pid_calc1;
			pid_calc1: next_state = pid_calc2;
			pid_calc2: next_state = pid_calc3;
			pid_calc3: next_state = pid_calc4;
			pid_calc4: next_state = pid_done;
			pid_done: if (wait_flag) next_state = pid_idle; // released by the sequencer.
			default: next_state = pid_idle;
		endcase
	end

	// The error history has to start from zero so that the first derivative
	// only sees the first error.
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			rotation_error <= '0;
			prev_rotation_error <= '0;
		end else if (state == pid_calc1) begin
			prev_rotation_error <= rotation_error;
			rotation_error <= rate_acc_t'(target_rotation) - rate_acc_t'(actual_rotation);
		end
	end

	// one arithmetic step per calc state.
	always_ff @(posedge us_clk) begin
		case (state)
			pid_calc1: begin
				term_i <= k_i * rate_acc_t'(angle_error); // inputs are still stable here.
			end
			pid_calc2: begin
				term_p <= k_p * rotation_error;
				error_change <= prev_rotation_error - rotation_error;
			end
			pid_calc3: begin
				term_d <= k_d * error_change;
			end
			pid_calc4: begin
				rotation_total <= term_p + term_i + term_d;
			end
			default: begin
			end
		endcase
	end

	always_comb begin
		if (rotation_total < rate_acc_t'(rate_min))
			total_sat = rate_min;
		else if (rotation_total > rate_acc_t'(rate_max))
			total_sat = rate_max;
		else
			total_sat = rate_t'(rotation_total);
	end

	// rate_out is rewritten with the same value while the unit waits in done.
	always_ff @(posedge us_clk) begin
		if (state == pid_done)
			rate_out <= total_sat;
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			pid_complete <= 1'b0;
		else
			pid_complete <= (state == pid_done) && !wait_flag; // drops with the release.
	end

endmodule

// ==== hdl/rate_controller.sv ====
`timescale 1ns/1ns

module rate_controller (
	output flight_pkg::rates_t rates,
	output logic rates_valid,
	output logic busy,
	input logic sample_strobe,
	input flight_pkg::axis_in_t roll_in,
	input flight_pkg::axis_in_t pitch_in,
	input flight_pkg::axis_in_t yaw_in,
	input logic resetn,
	input logic us_clk
);
	import flight_pkg::*;

	seq_state_t state;

	logic start_flag;
	logic wait_flag;
	logic accept; // a strobe that arrives while nothing is in flight.
	logic [2:0] pid_complete; // roll, pitch and yaw from bit 0 up.
	logic [2:0] pid_active;
	rate_t roll_rate, pitch_rate, yaw_rate;

	assign busy = (state != seq_idle) || (|pid_active);
	assign accept = sample_strobe && !busy;
	assign start_flag = accept; // all three axes start on the same edge.
	assign rates_valid = (state == seq_collect);
	assign wait_flag = (state == seq_collect);

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state <= seq_idle;
		end else begin
			case (state)
				seq_idle: if (accept) state <= seq_run;
				seq_run: if (&pid_complete) state <= seq_collect;
				seq_collect: state <= seq_idle;
				default: state <= seq_idle;
			endcase
		end
	end

	// results are taken on the way into collect so they are valid with rates_valid.
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			rates <= '0;
		end else if (state == seq_run && &pid_complete) begin
			rates.roll <= roll_rate;
			rates.pitch <= pitch_rate;
			rates.yaw <= yaw_rate;
		end
	end

	pid #(.k_p(roll_kp), .k_i(roll_ki), .k_d(roll_kd)) roll_pid (
		.rate_out(roll_rate),
		.pid_complete(pid_complete[0]),
		.pid_active(pid_active[0]),
		.target_rotation(roll_in.target),
		.actual_rotation(roll_in.actual),
		.angle_error(roll_in.angle_error),
		.start_flag(start_flag),
		.wait_flag(wait_flag),
		.resetn(resetn),
		.us_clk(us_clk)
	);

	pid #(.k_p(pitch_kp), .k_i(pitch_ki), .k_d(pitch_kd)) pitch_pid (
		.rate_out(pitch_rate),
		.pid_complete(pid_complete[1]),
		.pid_active(pid_active[1]),
		.target_rotation(pitch_in.target),
		.actual_rotation(pitch_in.actual),
		.angle_error(pitch_in.angle_error),
		.start_flag(start_flag),
		.wait_flag(wait_flag),
		.resetn(resetn),
		.us_clk(us_clk)
	);

	pid #(.k_p(yaw_kp), .k_i(yaw_ki), .k_d(yaw_kd)) yaw_pid (
		.rate_out(yaw_rate),
		.pid_complete(pid_complete[2]),
		.pid_active(pid_active[2]),
		.target_rotation(yaw_in.target),
		.actual_rotation(yaw_in.actual),
		.angle_error(yaw_in.angle_error),
		.start_flag(start_flag),
		.wait_flag(wait_flag),
		.resetn(resetn),
		.us_clk(us_clk)
	);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module flight_control_tb -f vlog.f

output=$(./obj_dir/Vflight_control_tb)
echo "$output"

if echo "$output" | grep -qx "Testbench passed"; then
	exit 0
fi
exit 1

// ==== testbench/flight_control_tb.sv ====
`timescale 1ns/1ns

module flight_control_tb;
	import flight_pkg::*;

	localparam int n_samples = 50;
	localparam int cycle_limit = n_samples * 12 + 40; // reset and drain margin on top.

	logic us_clk;
	logic resetn;
	logic sample_strobe;
	axis_in_t roll_in, pitch_in, yaw_in;
	motor_cmd_t throttle;
	motors_t motors;
	logic motors_valid;
	rates_t rates;
	logic busy;

	bit started; // set with the first strobe.
	bit accepted_now; // the strobe now on the inputs will be taken at the next edge.
	logic [7:0] valid_pipe; // bit k is set k edges after an accepted sampling edge.
	int prev_err [3]; // model error history for roll, pitch and yaw.
	rates_t exp_rates_q [$];
	motors_t exp_motors_q [$];
	rates_t chk_rates;
	motors_t chk_motors;
	int cycle_count;
	int rate_errors, motor_errors, timing_errors, stimulus_gaps;
	int sat_hits, clamp_low_hits, clamp_high_hits;

	flight_control_top flight_control_top_inst (
		.motors(motors),
		.motors_valid(motors_valid),
		.rates(rates),
		.busy(busy),
		.sample_strobe(sample_strobe),
		.roll_in(roll_in),
		.pitch_in(pitch_in),
		.yaw_in(yaw_in),
		.throttle(throttle),
		.resetn(resetn),
		.us_clk(us_clk)
	);

	always #20 us_clk = ~us_clk;

	// The expected result is moved into the check registers on the edge that raises motors_valid.
	always @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			valid_pipe <= '0;
		end else begin
			valid_pipe <= {valid_pipe[6:0], accepted_now};
			if (valid_pipe[6] && exp_rates_q.size() > 0) begin
				chk_rates <= exp_rates_q.pop_front();
				chk_motors <= exp_motors_q.pop_front();
			end
		end
	end

	always @(posedge us_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == cycle_limit) begin
			$display("Timeout: the run did not finish within %0d clock cycles.", cycle_limit);
			$display("Testbench failed");
			$finish;
		end
	end

	idle_after_reset: assert property (@(posedge us_clk) disable iff (!resetn)
		!started |-> (!motors_valid && !busy && rates == '0 && motors == '0))
		else begin
			timing_errors++;
			$display("ERROR %0t: outputs are not idle and zero before the first strobe", $time);
		end

	valid_timing: assert property (@(posedge us_clk) disable iff (!resetn)
		motors_valid == valid_pipe[7])
		else begin
			timing_errors++;
			$display("ERROR %0t: motors_valid is %0b, expected %0b", $time, motors_valid,
				valid_pipe[7]);
		end

	busy_timing: assert property (@(posedge us_clk) disable iff (!resetn)
		busy == (|valid_pipe[6:0]))
		else begin
			timing_errors++;
			$display("ERROR %0t: busy is %0b, expected %0b", $time, busy, |valid_pipe[6:0]);
		end

	rates_match: assert property (@(posedge us_clk) disable iff (!resetn)
		motors_valid |-> rates == chk_rates)
		else begin
			rate_errors++;
			$display("ERROR %0t: rates %0d %0d %0d, expected %0d %0d %0d", $time, rates.roll,
				rates.pitch, rates.yaw, chk_rates.roll, chk_rates.pitch, chk_rates.yaw);
		end

	motors_match: assert property (@(posedge us_clk) disable iff (!resetn)
		motors_valid |-> motors == chk_motors)
		else begin
			motor_errors++;
			$display("ERROR %0t: motors %0d %0d %0d %0d, expected %0d %0d %0d %0d", $time,
				motors.front_left, motors.front_right, motors.rear_left, motors.rear_right,
				chk_motors.front_left, chk_motors.front_right, chk_motors.rear_left,
				chk_motors.rear_right);
		end

	function automatic axis_in_t random_axis(input bit wide);
		axis_in_t a;
		if (wide) begin
			a.target = rate_t'($urandom); // full range, so the sums leave 16 bits.
			a.actual = imu_val_t'($urandom);
			a.angle_error = rate_t'($urandom);
		end else begin
			a.target = rate_t'(int'($urandom % 401) - 200);
			a.actual = imu_val_t'(int'($urandom % 401) - 200);
			a.angle_error = rate_t'(int'($urandom % 201) - 100);
		end
		return a;
	endfunction

	// PID of one axis: i on the angle error, p on the rate error, d on its decrease.
	function automatic int expected_axis_rate(input int axis, input axis_in_t a);
		int kp, ki, kd, err, sum;
		kp = (axis == 2) ? int'(yaw_kp) : (axis == 1) ? int'(pitch_kp) : int'(roll_kp);
		ki = (axis == 2) ? int'(yaw_ki) : (axis == 1) ? int'(pitch_ki) : int'(roll_ki);
		kd = (axis == 2) ? int'(yaw_kd) : (axis == 1) ? int'(pitch_kd) : int'(roll_kd);
		err = int'(a.target) - int'(a.actual);
		sum = ki * int'(a.angle_error) + kp * err + kd * (prev_err[axis] - err);
		prev_err[axis] = err;
		if (sum > 32767) begin
			sat_hits++;
			return 32767;
		end
		if (sum < -32768) begin
			sat_hits++;
			return -32768;
		end
		return sum;
	endfunction

	function automatic int expected_motor(input int mix);
		if (mix < 0) begin
			clamp_low_hits++;
			return 0;
		end
		if (mix > 4095) begin
			clamp_high_hits++;
			return 4095;
		end
		return mix;
	endfunction

	task automatic record_expected();
		rates_t r;
		motors_t m;
		int rv, pv, yv, thr;
		rv = expected_axis_rate(0, roll_in);
		pv = expected_axis_rate(1, pitch_in);
		yv = expected_axis_rate(2, yaw_in);
		thr = int'(throttle);
		r.roll = rate_t'(rv);
		r.pitch = rate_t'(pv);
		r.yaw = rate_t'(yv);
		m.front_left = motor_cmd_t'(expected_motor(thr + rv + pv - yv));
		m.front_right = motor_cmd_t'(expected_motor(thr - rv + pv + yv));
		m.rear_left = motor_cmd_t'(expected_motor(thr + rv - pv + yv));
		m.rear_right = motor_cmd_t'(expected_motor(thr - rv - pv - yv));
		exp_rates_q.push_back(r);
		exp_motors_q.push_back(m);
	endtask

	task automatic run_sample(input int n);
		int mode;
		mode = n % 4;
		while (busy)
			@(negedge us_clk);
		roll_in = random_axis(mode == 1);
		pitch_in = random_axis(mode == 1);
		yaw_in = random_axis(mode == 1);
		case (mode)
			0: throttle = motor_cmd_t'(1000 + $urandom % 2000);
			1: throttle = motor_cmd_t'($urandom % 4096);
			2: throttle = motor_cmd_t'($urandom % 64); // pushes motors below zero.
			default: throttle = motor_cmd_t'(4032 + $urandom % 64);
		endcase
		sample_strobe = 1'b1;
		accepted_now = 1'b1;
		started = 1'b1;
		record_expected();
		@(negedge us_clk);
		sample_strobe = 1'b0;
		accepted_now = 1'b0;
		@(negedge us_clk); // calc1 has taken the axis inputs by now.
		if (n % 3 == 2) begin
			roll_in = random_axis(1'b1);
			pitch_in = random_axis(1'b1);
			yaw_in = random_axis(1'b1);
			sample_strobe = 1'b1; // arrives while busy and must be dropped.
			@(negedge us_clk);
			sample_strobe = 1'b0;
		end
		if ($urandom % 2 == 1)
			@(negedge us_clk);
	endtask

	initial begin
		void'($urandom(32'he101));
		us_clk = 1'b0;
		resetn = 1'b0;
		sample_strobe = 1'b0;
		roll_in = '0;
		pitch_in = '0;
		yaw_in = '0;
		throttle = '0;
		repeat (10) @(posedge us_clk);
		@(negedge us_clk);
		resetn = 1'b1;
		repeat (2) @(negedge us_clk); // idle outputs are checked here.
		for (int n = 0; n < n_samples; n++)
			run_sample(n);
		while (exp_rates_q.size() != 0 || valid_pipe != 0)
			@(negedge us_clk);
		if (sat_hits == 0) begin
			stimulus_gaps++;
			$display("No rate output was driven into saturation during the run.");
		end
		if (clamp_low_hits == 0 || clamp_high_hits == 0) begin
			stimulus_gaps++;
			$display("The motor commands did not reach both ends of the motor range.");
		end
		$display("rate errors %0d, motor errors %0d, timing errors %0d, stimulus gaps %0d",
			rate_errors, motor_errors, timing_errors, stimulus_gaps);
		if (rate_errors + motor_errors + timing_errors + stimulus_gaps == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== vlog.f ====
hdl/flight_pkg.sv
hdl/pid.sv
hdl/rate_controller.sv
hdl/motor_mixer.sv
hdl/flight_control_top.sv
testbench/flight_control_tb.sv
